//--- design/csr_pkg.sv
// CSR unit shared definitions
// addresses, opcodes, causes and request structs

`default_nettype none

package csr_pkg;

    //////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////
    localparam int XLEN       = 32;
    localparam int CSR_ADDR_W = 12;
    // bit 5 interrupt flag, bits 4..0 cause
    localparam int EXP_CODE_W = 6;

    //////////////////////////////////////////////////
    // csr address map
    //////////////////////////////////////////////////
    localparam logic [CSR_ADDR_W-1:0] ADDR_MSTATUS  = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MEPC     = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MCAUSE   = 12'h342;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MCPUID   = 12'hF00;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MIMPID   = 12'hF01;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MESTATUS = 12'h7C0;

    // identity constants, read only
    localparam logic [XLEN-1:0] MCPUID_VAL = 32'h0000_0100;
    localparam logic [XLEN-1:0] MIMPID_VAL = 32'h0000_8000;

    // status words always report machine mode in bits 2..1
    localparam logic [1:0] STATUS_MODE_BITS = 2'b11;

    //////////////////////////////////////////////////
    // instruction encodings
    //////////////////////////////////////////////////
    localparam logic [6:0]      OPC_SYSTEM  = 7'b111_0011;
    localparam logic [XLEN-1:0] INSTR_ECALL = 32'h0000_0073;
    localparam logic [XLEN-1:0] INSTR_MRET  = 32'h3020_0073;

    typedef enum logic [1:0] {
        CSR_OP_NOP   = 2'b00,
        CSR_OP_WRITE = 2'b01,
        CSR_OP_SET   = 2'b10,
        CSR_OP_CLEAR = 2'b11
    } csr_op_e;

    //////////////////////////////////////////////////
    // trap causes
    //////////////////////////////////////////////////
    localparam logic [EXP_CODE_W-1:0] CAUSE_ILLEGAL = 6'd2;
    localparam logic [EXP_CODE_W-1:0] CAUSE_ECALL   = 6'd11;
    localparam logic [EXP_CODE_W-1:0] CAUSE_EXT_IRQ = 6'h20 | 6'd11;

    // decoded csr or system request, one per retiring instruction
    typedef struct packed {
        logic                  valid;
        csr_op_e               op;
        logic [CSR_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       wdata;
        logic [XLEN-1:0]       pc;
        logic                  is_ecall;
        logic                  is_mret;
        logic                  illegal;
    } csr_req_t;

    // trap save / mret restore command to the register file
    typedef struct packed {
        logic                  save;
        logic                  restore;
        logic [EXP_CODE_W-1:0] code;
        logic [XLEN-1:0]       epc;
    } trap_cmd_t;

endpackage

`default_nettype wire

//--- design/csr_decode.sv
// CSR instruction decoder

`timescale 1ns/1ps
`default_nettype none

module csr_decode
    import csr_pkg::*;
(
    input  wire logic            instr_valid_i,
    input  wire logic [XLEN-1:0] instr_i,
    input  wire logic [XLEN-1:0] pc_i,
    input  wire logic [XLEN-1:0] rs1_data_i,
    output csr_req_t             req_o
);

    //////////////////////////////////////////////////
    // instruction fields
    //////////////////////////////////////////////////
    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [4:0]            rs1_idx;
    logic [CSR_ADDR_W-1:0] csr_addr;

    logic    is_system;
    logic    is_csr;
    logic    is_ecall;
    logic    is_mret;
    logic    addr_mapped;
    logic    addr_ro;
    csr_op_e op;

    // csr and system formats share field positions
    assign opcode   = instr_i[6:0];
    assign funct3   = instr_i[14:12];
    assign rs1_idx  = instr_i[19:15];
    assign csr_addr = instr_i[31:20];

    assign is_system = (opcode == OPC_SYSTEM);
    // funct3 low bits zero means priv group or reserved
    assign is_csr    = is_system && (funct3[1:0] != 2'b00);
    assign is_ecall  = (instr_i == INSTR_ECALL);
    assign is_mret   = (instr_i == INSTR_MRET);

    //////////////////////////////////////////////////
    // op select
    //////////////////////////////////////////////////
    always_comb begin
        case (funct3[1:0])
            2'b01:   op = CSR_OP_WRITE;
            2'b10:   op = CSR_OP_SET;
            2'b11:   op = CSR_OP_CLEAR;
            default: op = CSR_OP_NOP;
        endcase
        // set/clear with x0 or zero uimm writes nothing
        if ((op == CSR_OP_SET || op == CSR_OP_CLEAR) && rs1_idx == 5'd0) begin
            op = CSR_OP_NOP;
        end
        if (!is_csr) begin
            op = CSR_OP_NOP;
        end
    end

    //////////////////////////////////////////////////
    // address checks
    //////////////////////////////////////////////////
    always_comb begin
        case (csr_addr)
            ADDR_MSTATUS, ADDR_MEPC, ADDR_MCAUSE,
            ADDR_MCPUID, ADDR_MIMPID, ADDR_MESTATUS: addr_mapped = 1'b1;
            default:                                 addr_mapped = 1'b0;
        endcase
    end

    // identity registers
    assign addr_ro = (csr_addr == ADDR_MCPUID) || (csr_addr == ADDR_MIMPID);

    //////////////////////////////////////////////////
    // request
    //////////////////////////////////////////////////
    always_comb begin
        req_o.valid    = instr_valid_i && (is_csr || is_ecall || is_mret);
        req_o.op       = op;
        req_o.addr     = csr_addr;
        // funct3 bit 2 selects the immediate forms
        req_o.wdata    = funct3[2] ? {{(XLEN-5){1'b0}}, rs1_idx} : rs1_data_i;
        req_o.pc       = pc_i;
        req_o.is_ecall = instr_valid_i && is_ecall;
        req_o.is_mret  = instr_valid_i && is_mret;
        // unmapped, or any real write to a read-only register
        req_o.illegal  = instr_valid_i && is_csr &&
                         (!addr_mapped || (addr_ro && op != CSR_OP_NOP));
    end

endmodule

`default_nettype wire

//--- design/csr_retire.sv
// CSR retire stage and trap decision

`timescale 1ns/1ps
`default_nettype none

module csr_retire
    import csr_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     arst_n_i,
    input  wire csr_req_t req_i,
    input  wire logic     irq_i,
    input  wire logic     ie_i,
    output csr_req_t      acc_o,
    output trap_cmd_t     trap_o,
    output logic          rd_valid_o
);

    //////////////////////////////////////////////////
    // one-entry retire register
    //////////////////////////////////////////////////
    logic     valid_q;
    logic     irq_q;
    csr_req_t req_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
            irq_q   <= 1'b0;
        end else begin
            valid_q <= req_i.valid;
            irq_q   <= irq_i;
        end
    end

    // payload only, qualified by valid_q
    always_ff @(posedge clk) begin
        req_q <= req_i;
    end

    //////////////////////////////////////////////////
    // trap priority
    //////////////////////////////////////////////////
    logic take_irq;
    logic take_ill;
    logic take_ecall;
    logic take_mret;
    logic take_acc;

    // ie_i already holds the write of the previous instruction
    // interrupt fires with or without a retiring csr op
    assign take_irq   = irq_q && ie_i;
    assign take_ill   = !take_irq && valid_q && req_q.illegal;
    assign take_ecall = !take_irq && valid_q && req_q.is_ecall;
    assign take_mret  = !take_irq && valid_q && req_q.is_mret;
    // plain legal access left over
    assign take_acc   = !take_irq && valid_q && !req_q.illegal &&
                        !req_q.is_ecall && !req_q.is_mret;

    always_comb begin
        trap_o.save    = take_irq || take_ill || take_ecall;
        trap_o.restore = take_mret;
        if (take_irq) begin
            trap_o.code = CAUSE_EXT_IRQ;
        end else if (take_ill) begin
            trap_o.code = CAUSE_ILLEGAL;
        end else begin
            trap_o.code = CAUSE_ECALL;
        end
        trap_o.epc = req_q.pc;
    end

    // cancelled or illegal access reaches the file as nop
    always_comb begin
        acc_o       = req_q;
        acc_o.valid = take_acc;
        if (!take_acc) begin
            acc_o.op = CSR_OP_NOP;
        end
    end

    assign rd_valid_o = take_acc;

    // decode never marks mret illegal, so a trap and a restore never meet
    assert property (@(posedge clk) disable iff (!arst_n_i)
        !(trap_o.save && trap_o.restore))
        else $error("trap save and mret restore in the same cycle");

endmodule

`default_nettype wire

//--- design/csr_file.sv
// machine mode CSR register file

`timescale 1ns/1ps
`default_nettype none

module csr_file
    import csr_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       arst_n_i,
    input  wire csr_req_t   acc_i,
    input  wire trap_cmd_t  trap_i,
    output logic [XLEN-1:0] rd_data_o,
    output logic            ie_o
);

    //////////////////////////////////////////////////
    // state
    //////////////////////////////////////////////////
    logic                  mstatus_ie_q;
    logic                  mstatus_ie_d;
    logic                  mestatus_ie_q;
    logic                  mestatus_ie_d;
    logic [XLEN-1:0]       mepc_q;
    logic [XLEN-1:0]       mepc_d;
    logic [EXP_CODE_W-1:0] mcause_q;
    logic [EXP_CODE_W-1:0] mcause_d;

    logic [XLEN-1:0] wr_data;
    logic            wr_en;

    //////////////////////////////////////////////////
    // read mux
    //////////////////////////////////////////////////
    always_comb begin
        case (acc_i.addr)
            ADDR_MSTATUS:  rd_data_o = {{(XLEN-3){1'b0}}, STATUS_MODE_BITS, mstatus_ie_q};
            ADDR_MEPC:     rd_data_o = mepc_q;
            // interrupt flag goes to the msb
            ADDR_MCAUSE:   rd_data_o = {mcause_q[5], {(XLEN-6){1'b0}}, mcause_q[4:0]};
            ADDR_MCPUID:   rd_data_o = MCPUID_VAL;
            ADDR_MIMPID:   rd_data_o = MIMPID_VAL;
            ADDR_MESTATUS: rd_data_o = {{(XLEN-3){1'b0}}, STATUS_MODE_BITS, mestatus_ie_q};
            default:       rd_data_o = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // write / set / clear combine
    //////////////////////////////////////////////////
    always_comb begin
        wr_en = acc_i.valid;
        case (acc_i.op)
            CSR_OP_WRITE: wr_data = acc_i.wdata;
            CSR_OP_SET:   wr_data = rd_data_o | acc_i.wdata;
            CSR_OP_CLEAR: wr_data = rd_data_o & ~acc_i.wdata;
            default: begin
                wr_data = rd_data_o;
                wr_en   = 1'b0;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // next state
    //////////////////////////////////////////////////
    always_comb begin
        mstatus_ie_d  = mstatus_ie_q;
        mestatus_ie_d = mestatus_ie_q;
        mepc_d        = mepc_q;
        mcause_d      = mcause_q;

        if (wr_en) begin
            case (acc_i.addr)
                // status words keep only the enable bit
                ADDR_MSTATUS:  mstatus_ie_d  = wr_data[0];
                ADDR_MEPC:     mepc_d        = wr_data;
                ADDR_MCAUSE:   mcause_d      = {wr_data[XLEN-1], wr_data[4:0]};
                ADDR_MESTATUS: mestatus_ie_d = wr_data[0];
                default: begin
                end
            endcase
        end

        // trap save wins over a csr write
        if (trap_i.save) begin
            mcause_d      = trap_i.code;
            mepc_d        = trap_i.epc;
            mestatus_ie_d = mstatus_ie_q;
            mstatus_ie_d  = 1'b0;
        end

        // mret
        if (trap_i.restore) begin
            mstatus_ie_d = mestatus_ie_q;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mstatus_ie_q  <= 1'b0;
            mestatus_ie_q <= 1'b0;
            mepc_q        <= '0;
            mcause_q      <= '0;
        end else begin
            mstatus_ie_q  <= mstatus_ie_d;
            mestatus_ie_q <= mestatus_ie_d;
            mepc_q        <= mepc_d;
            mcause_q      <= mcause_d;
        end
    end

    assign ie_o = mstatus_ie_q;

    // retire stage must cancel the access whenever it saves a trap
    assert property (@(posedge clk) disable iff (!arst_n_i)
        !(acc_i.valid && (trap_i.save || acc_i.illegal)))
        else $error("csr access presented during trap save or while illegal");

endmodule

`default_nettype wire

//--- design/csr_unit_top.sv
// CSR unit top level

`timescale 1ns/1ps
`default_nettype none

module csr_unit_top
    import csr_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  arst_n_i,
    // retiring instruction
    input  wire logic                  instr_valid_i,
    input  wire logic [XLEN-1:0]       instr_i,
    input  wire logic [XLEN-1:0]       pc_i,
    input  wire logic [XLEN-1:0]       rs1_data_i,
    input  wire logic                  irq_i,
    // read result
    output logic                       rd_valid_o,
    output logic [XLEN-1:0]            rd_data_o,
    // trap report
    output logic                       trap_o,
    output logic [EXP_CODE_W-1:0]      trap_code_o,
    output logic [XLEN-1:0]            trap_epc_o,
    output logic                       ie_o
);

    //////////////////////////////////////////////////
    // internal links
    //////////////////////////////////////////////////
    csr_req_t  dec_req;
    csr_req_t  acc_req;
    trap_cmd_t trap_cmd;

    csr_decode u_decode (
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .rs1_data_i    (rs1_data_i),
        .req_o         (dec_req)
    );

    // ie feeds back for the interrupt gate
    csr_retire u_retire (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .req_i      (dec_req),
        .irq_i      (irq_i),
        .ie_i       (ie_o),
        .acc_o      (acc_req),
        .trap_o     (trap_cmd),
        .rd_valid_o (rd_valid_o)
    );

    csr_file u_file (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .acc_i     (acc_req),
        .trap_i    (trap_cmd),
        .rd_data_o (rd_data_o),
        .ie_o      (ie_o)
    );

    // trap report fields
    assign trap_o      = trap_cmd.save;
    assign trap_code_o = trap_cmd.code;
    assign trap_epc_o  = trap_cmd.epc;

endmodule

`default_nettype wire

//--- tests/clk_gen.sv
// testbench clock and reset

`timescale 1ns/1ps
`default_nettype none

module clk_gen (
    output logic clk_o,
    output logic arst_n_o
);

    // 40 ns period
    initial begin
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o;
    end

    // reset held 8 cycles, released just after an edge
    initial begin
        arst_n_o = 1'b0;
        repeat (8) @(posedge clk_o);
        #2 arst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

//--- tests/tb_csr_unit.sv
// CSR unit testbench
// directed and random checks against a reference model

`timescale 1ns/1ps
`default_nettype none

module tb_csr_unit
    import csr_pkg::*;
();

    // funct3 of the six Zicsr forms
    typedef enum logic [2:0] {
        F3_RW  = 3'd1,
        F3_RS  = 3'd2,
        F3_RC  = 3'd3,
        F3_RWI = 3'd5,
        F3_RSI = 3'd6,
        F3_RCI = 3'd7
    } funct3_e;

    // model copy of the architectural registers
    typedef struct packed {
        logic                  ie;
        logic                  eie;
        logic [XLEN-1:0]       epc;
        logic [EXP_CODE_W-1:0] cause;
    } model_state_t;

    // expected outputs of one retire slot, plus model state after it
    typedef struct packed {
        logic                  rd_valid;
        logic [XLEN-1:0]       rd_data;
        logic                  trap;
        logic [EXP_CODE_W-1:0] code;
        logic [XLEN-1:0]       epc;
        logic                  ie;
        model_state_t          nxt;
    } expect_t;

    logic                  clk;
    logic                  arst_n;
    logic                  instr_valid;
    logic [XLEN-1:0]       instr;
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       rs1_data;
    logic                  irq;
    logic                  rd_valid;
    logic [XLEN-1:0]       rd_data;
    logic                  trap;
    logic [EXP_CODE_W-1:0] trap_code;
    logic [XLEN-1:0]       trap_epc;
    logic                  ie;

    model_state_t    state;
    expect_t         exp_q;
    string           exp_name;
    logic [XLEN-1:0] next_pc;
    integer          seed;
    // slots handed to the compare, and slots it has checked
    int              issued     = 0;
    int              compared   = 0;
    int              checks     = 0;
    int              value_errs = 0;
    int              other_errs = 0;

    clk_gen u_clk (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    csr_unit_top u_dut (
        .clk           (clk),
        .arst_n_i      (arst_n),
        .instr_valid_i (instr_valid),
        .instr_i       (instr),
        .pc_i          (pc),
        .rs1_data_i    (rs1_data),
        .irq_i         (irq),
        .rd_valid_o    (rd_valid),
        .rd_data_o     (rd_data),
        .trap_o        (trap),
        .trap_code_o   (trap_code),
        .trap_epc_o    (trap_epc),
        .ie_o          (ie)
    );

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////
    function automatic logic [XLEN-1:0] model_read(input model_state_t st,
                                                   input logic [CSR_ADDR_W-1:0] addr);
        case (addr)
            // status words report machine mode in bits 2..1
            ADDR_MSTATUS:  return {29'd0, 2'b11, st.ie};
            ADDR_MEPC:     return st.epc;
            ADDR_MCAUSE:   return {st.cause[5], 26'd0, st.cause[4:0]};
            ADDR_MCPUID:   return 32'h0000_0100;
            ADDR_MIMPID:   return 32'h0000_8000;
            ADDR_MESTATUS: return {29'd0, 2'b11, st.eie};
            default:       return 32'd0;
        endcase
    endfunction

    function automatic expect_t predict(input model_state_t st, input logic valid,
                                        input logic [XLEN-1:0] ins,
                                        input logic [XLEN-1:0] at_pc,
                                        input logic [XLEN-1:0] rs1, input logic irq_lvl);
        expect_t               e;
        logic [2:0]            f3;
        logic [4:0]            src;
        logic [CSR_ADDR_W-1:0] addr;
        logic                  is_csr;
        logic                  writes;
        logic                  illegal;
        logic [XLEN-1:0]       old_val;
        logic [XLEN-1:0]       opnd;
        logic [XLEN-1:0]       new_val;
        f3     = ins[14:12];
        src    = ins[19:15];
        addr   = ins[31:20];
        is_csr = valid && ins[6:0] == 7'h73 && f3[1:0] != 2'b00;
        // csrrw always writes, set and clear only with a nonzero source field
        writes  = f3[1:0] == 2'b01 || src != 5'd0;
        illegal = is_csr && (!(addr inside {ADDR_MSTATUS, ADDR_MEPC, ADDR_MCAUSE,
                                            ADDR_MCPUID, ADDR_MIMPID, ADDR_MESTATUS}) ||
                             ((addr == ADDR_MCPUID || addr == ADDR_MIMPID) && writes));
        opnd    = f3[2] ? {27'd0, src} : rs1;
        old_val = model_read(st, addr);
        case (f3[1:0])
            2'b01:   new_val = opnd;
            2'b10:   new_val = old_val | opnd;
            default: new_val = old_val & ~opnd;
        endcase
        e     = '0;
        e.ie  = st.ie;
        e.epc = at_pc;
        e.nxt = st;
        // priority: interrupt, illegal, ecall, then mret or access
        if (irq_lvl && st.ie) begin
            e.trap = 1'b1;
            // interrupt flag plus cause 11
            e.code = 6'h2B;
        end else if (illegal) begin
            e.trap = 1'b1;
            e.code = 6'd2;
        end else if (valid && ins == 32'h0000_0073) begin
            e.trap = 1'b1;
            e.code = 6'd11;
        end else if (valid && ins == 32'h3020_0073) begin
            e.nxt.ie = st.eie;
        end else if (is_csr) begin
            e.rd_valid = 1'b1;
            e.rd_data  = old_val;
            if (writes) begin
                case (addr)
                    ADDR_MSTATUS:  e.nxt.ie    = new_val[0];
                    ADDR_MEPC:     e.nxt.epc   = new_val;
                    ADDR_MCAUSE:   e.nxt.cause = {new_val[31], new_val[4:0]};
                    ADDR_MESTATUS: e.nxt.eie   = new_val[0];
                    default: begin
                    end
                endcase
            end
        end
        // every trap saves cause and pc, stacks the enable and masks
        if (e.trap) begin
            e.nxt.cause = e.code;
            e.nxt.epc   = at_pc;
            e.nxt.eie   = st.ie;
            e.nxt.ie    = 1'b0;
        end
        return e;
    endfunction

    //////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////
    function automatic logic [XLEN-1:0] csr_instr(input logic [2:0] f3,
                                                  input logic [CSR_ADDR_W-1:0] addr,
                                                  input logic [4:0] src);
        // rd is x1, never written back here
        return {addr, src, f3, 5'd1, 7'h73};
    endfunction

    function automatic logic [CSR_ADDR_W-1:0] map_addr(input logic [2:0] idx);
        case (idx)
            3'd0:    return ADDR_MSTATUS;
            3'd1:    return ADDR_MEPC;
            3'd2:    return ADDR_MCAUSE;
            3'd3:    return ADDR_MCPUID;
            3'd4:    return ADDR_MIMPID;
            3'd5:    return ADDR_MESTATUS;
            // unmapped neighbour of mstatus
            3'd6:    return 12'h301;
            default: return ADDR_MEPC;
        endcase
    endfunction

    // drive one slot at edge+2, hand it to the compare, move to next edge+2
    task automatic retire_instr(input string name, input logic valid,
                                input logic [XLEN-1:0] ins, input logic [XLEN-1:0] rs1,
                                input logic irq_lvl);
        instr_valid = valid;
        instr       = ins;
        pc          = next_pc;
        rs1_data    = rs1;
        irq         = irq_lvl;
        exp_q       = predict(state, valid, ins, next_pc, rs1, irq_lvl);
        state       = exp_q.nxt;
        exp_name    = name;
        issued      = issued + 1;
        next_pc     = next_pc + 32'd4;
        @(posedge clk);
        #2;
    endtask

    task automatic do_csr(input string name, input funct3_e f3,
                          input logic [CSR_ADDR_W-1:0] addr, input logic [4:0] src,
                          input logic [XLEN-1:0] rs1, input logic irq_lvl);
        retire_instr(name, 1'b1, csr_instr(f3, addr, src), rs1, irq_lvl);
    endtask

    // csrrs with x0 on every mapped register
    task automatic read_all(input string name);
        int k;
        for (k = 0; k < 6; k++) begin
            do_csr(name, F3_RS, map_addr(3'(k)), 5'd0, 32'hFFFF_FFFF, 1'b0);
        end
    endtask

    task automatic run_random(input int count);
        logic [XLEN-1:0] r;
        logic [XLEN-1:0] data;
        logic [XLEN-1:0] ins;
        int              n;
        for (n = 0; n < count; n++) begin
            r    = $random(seed);
            data = $random(seed);
            case (r[2:0])
                3'd0:    ins = r[3] ? 32'h0000_0073 : 32'h3020_0073;
                // addi, not a unit instruction
                3'd4:    ins = {r[31:7], 7'h13};
                default: ins = csr_instr(r[2:0], map_addr(r[10:8]), r[11] ? 5'd0 : r[16:12]);
            endcase
            retire_instr("random", r[20:17] != 4'd0, ins, data, r[23:21] == 3'd0);
        end
    endtask

    //////////////////////////////////////////////////
    // comparing process
    //////////////////////////////////////////////////
    task automatic log_mismatch(input string field, input logic [XLEN-1:0] expv,
                                input logic [XLEN-1:0] act);
        $display("ERR %s %s expected %h actual %h", exp_name, field, expv, act);
        value_errs = value_errs + 1;
    endtask

    // outputs settle one edge after sampling, checked 1 ns later
    always @(posedge clk) begin
        #1;
        if (compared != issued) begin
            checks = checks + 1;
            if (rd_valid !== exp_q.rd_valid)
                log_mismatch("rd_valid", 32'(exp_q.rd_valid), 32'(rd_valid));
            if (exp_q.rd_valid && rd_data !== exp_q.rd_data)
                log_mismatch("rd_data", exp_q.rd_data, rd_data);
            if (trap !== exp_q.trap)
                log_mismatch("trap", 32'(exp_q.trap), 32'(trap));
            if (exp_q.trap && trap_code !== exp_q.code)
                log_mismatch("trap_code", 32'(exp_q.code), 32'(trap_code));
            if (exp_q.trap && trap_epc !== exp_q.epc)
                log_mismatch("trap_epc", exp_q.epc, trap_epc);
            if (ie !== exp_q.ie)
                log_mismatch("ie", 32'(exp_q.ie), 32'(ie));
            compared = compared + 1;
        end
    end

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////
    initial begin
        int cnt;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        rs1_data    = '0;
        irq         = 1'b0;
        state       = '0;
        exp_q       = '0;
        next_pc     = 32'h0000_1000;
        seed        = 32'h727e;

        cnt = 0;
        while (arst_n !== 1'b1 && cnt < 20) begin
            @(posedge clk);
            cnt = cnt + 1;
        end
        if (arst_n !== 1'b1) begin
            $display("timeout: reset was never released");
            other_errs = other_errs + 1;
        end else begin
            @(posedge clk);
            #2;
            // reset values, set with x0 writes nothing
            retire_instr("idle", 1'b0, 32'd0, 32'd0, 1'b0);
            read_all("reset read");
            // read-modify-write, register and immediate forms
            do_csr("csrrw mepc", F3_RW, ADDR_MEPC, 5'd5, 32'h1234_5678, 1'b0);
            do_csr("csrrs mepc", F3_RS, ADDR_MEPC, 5'd6, 32'h8000_000F, 1'b0);
            do_csr("csrrc mepc", F3_RC, ADDR_MEPC, 5'd7, 32'h0000_0FF0, 1'b0);
            do_csr("csrrwi mcause", F3_RWI, ADDR_MCAUSE, 5'd19, 32'd0, 1'b0);
            do_csr("csrrsi mcause", F3_RSI, ADDR_MCAUSE, 5'd8, 32'd0, 1'b0);
            do_csr("csrrci mcause", F3_RCI, ADDR_MCAUSE, 5'd3, 32'd0, 1'b0);
            do_csr("csrrw mcause", F3_RW, ADDR_MCAUSE, 5'd1, 32'hFFFF_FFFF, 1'b0);
            do_csr("csrrw mstatus", F3_RW, ADDR_MSTATUS, 5'd1, 32'hFFFF_FFFE, 1'b0);
            do_csr("csrrwi mestatus", F3_RWI, ADDR_MESTATUS, 5'd31, 32'd0, 1'b0);
            do_csr("csrrci mestatus", F3_RCI, ADDR_MESTATUS, 5'd1, 32'd0, 1'b0);
            read_all("rmw read");
            // illegal accesses trap, x0 set on mcpuid does not
            do_csr("unmapped", F3_RS, 12'h123, 5'd0, 32'd0, 1'b0);
            do_csr("csrrw mcpuid", F3_RW, ADDR_MCPUID, 5'd0, 32'd0, 1'b0);
            do_csr("csrrsi mimpid", F3_RSI, ADDR_MIMPID, 5'd3, 32'd0, 1'b0);
            do_csr("set x0 mcpuid", F3_RS, ADDR_MCPUID, 5'd0, 32'd0, 1'b0);
            read_all("illegal read");
            // ecall with interrupts enabled
            do_csr("enable", F3_RSI, ADDR_MSTATUS, 5'd1, 32'd0, 1'b0);
            retire_instr("ecall", 1'b1, 32'h0000_0073, 32'd0, 1'b0);
            read_all("ecall read");
            // irq masked, then the enable lands, then pre-emption
            do_csr("irq masked", F3_RS, ADDR_MSTATUS, 5'd0, 32'd0, 1'b1);
            do_csr("enable irq", F3_RSI, ADDR_MSTATUS, 5'd1, 32'd0, 1'b1);
            do_csr("irq preempt", F3_RW, ADDR_MEPC, 5'd2, 32'hDEAD_BEE0, 1'b1);
            read_all("irq read");
            retire_instr("mret", 1'b1, 32'h3020_0073, 32'd0, 1'b0);
            read_all("mret read");
            run_random(400);
            instr_valid = 1'b0;
            irq         = 1'b0;
            cnt = 0;
            while (compared != issued && cnt < 10) begin
                @(posedge clk);
                cnt = cnt + 1;
            end
            if (compared != issued) begin
                $display("timeout: last result was never compared");
                other_errs = other_errs + 1;
            end
        end

        $display("checks %0d, value errors %0d, other errors %0d",
                 checks, value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
design/csr_pkg.sv
design/csr_decode.sv
design/csr_retire.sv
design/csr_file.sv
design/csr_unit_top.sv
tests/clk_gen.sv
tests/tb_csr_unit.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the CSR unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_csr_unit \
    -f tb.f \
    -o sim_csr_unit

./obj_dir/sim_csr_unit > sim.log
cat sim.log

if grep -qx "Testbench passed" sim.log; then
    echo "run.sh: simulation ok"
else
    echo "run.sh: simulation reported a failure"
    exit 1
fi
